//--- rtl/ssb_pkg.sv
/* sparse sample buffer shared definitions
   widths, depths, start/stop command encoding and the bundled signal types */
package ssb_pkg;

  localparam int channels = 2;  // input channels
  localparam int ch_sel_width = 1;  // bits to select a channel
  localparam int sample_width = 16;
  localparam int data_depth = 64;  // entries per channel bank, data buffer
  localparam int tstamp_depth = 16;  // entries per channel bank, timestamp buffer
  localparam int index_width = 8;  // stored-sample count per channel
  localparam int clock_width = 24;  // cycles since capture start
  localparam int tstamp_width = clock_width + index_width;  // clock in the upper bits
  localparam int out_width = 32;  // output stream word

  // thresholds out of reach of any 16-bit signed sample
  localparam logic [sample_width-1:0] thresh_high_init = 16'h7fff;
  localparam logic [sample_width-1:0] thresh_low_init = 16'h8000;

  // bit 1 requests start, bit 0 requests stop; both together acts as stop
  typedef enum logic [1:0] {
    cmd_none       = 2'b00,
    cmd_stop       = 2'b01,
    cmd_start      = 2'b10,
    cmd_start_stop = 2'b11
  } ssb_cmd_e;

  // raw samples, all channels in parallel, no back-pressure
  typedef struct packed {
    logic                                     valid;
    logic [channels-1:0][sample_width-1:0]    data;
  } samples_t;

  // realtime threshold write, signed values per channel
  typedef struct packed {
    logic                                     valid;
    logic [channels-1:0][sample_width-1:0]    high;
    logic [channels-1:0][sample_width-1:0]    low;
  } thresholds_t;

  // discriminator to data buffer
  typedef struct packed {
    logic [channels-1:0]                      valid;
    logic [channels-1:0][sample_width-1:0]    data;
  } disc_data_t;

  // discriminator to timestamp buffer
  typedef struct packed {
    logic [channels-1:0]                      valid;
    logic [channels-1:0][tstamp_width-1:0]    tstamp;
  } disc_tstamp_t;

  // valid/ready stream word, ready travels on its own wire
  typedef struct packed {
    logic [out_width-1:0]                     data;
    logic                                     valid;
    logic                                     last;
  } out_stream_t;

endpackage

//--- rtl/sample_discriminator.sv
/* hysteresis discriminator, one per channel
   forwards high-phase samples and one timestamp per rising edge */
`timescale 1ns/10ps
module sample_discriminator (
  input  logic                   clk,
  input  logic                   reset,
  input  ssb_pkg::samples_t      samples_in,
  input  ssb_pkg::thresholds_t   thresholds_in,
  input  logic                   start,  // new capture, clears all tracking state
  output ssb_pkg::disc_data_t    data_out,
  output ssb_pkg::disc_tstamp_t  tstamps_out
);

  logic [ssb_pkg::channels-1:0][ssb_pkg::sample_width-1:0] thresh_high;
  logic [ssb_pkg::channels-1:0][ssb_pkg::sample_width-1:0] thresh_low;
  logic [ssb_pkg::channels-1:0]                           is_high;
  logic [ssb_pkg::channels-1:0]                           next_high;  // state after this sample
  logic [ssb_pkg::channels-1:0]                           rising;
  logic [ssb_pkg::channels-1:0][ssb_pkg::index_width-1:0] index;  // samples forwarded so far
  logic [ssb_pkg::clock_width-1:0]                        clock_count;

  // signed compare against the held thresholds
  always_comb begin
    for (int i = 0; i < ssb_pkg::channels; i++) begin
      if ($signed(samples_in.data[i]) > $signed(thresh_high[i])) begin
        next_high[i] = 1'b1;
      end else if ($signed(samples_in.data[i]) < $signed(thresh_low[i])) begin
        next_high[i] = 1'b0;
      end else begin
        next_high[i] = is_high[i];  // in the band, hold
      end
    end
  end

  assign rising = next_high & ~is_high;

  // thresholds, realtime write with no handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      thresh_high <= {ssb_pkg::channels{ssb_pkg::thresh_high_init}};
      thresh_low <= {ssb_pkg::channels{ssb_pkg::thresh_low_init}};
    end else if (thresholds_in.valid) begin
      thresh_high <= thresholds_in.high;
      thresh_low <= thresholds_in.low;
    end
  end

  // tracking state and output valids
  always_ff @(posedge clk) begin
    if (reset) begin
      is_high <= '0;
      index <= '0;
      clock_count <= '0;
      data_out.valid <= '0;
      tstamps_out.valid <= '0;
    end else if (start) begin
      is_high <= '0;  // start wins over a sample in the same cycle
      index <= '0;
      clock_count <= '0;
      data_out.valid <= '0;
      tstamps_out.valid <= '0;
    end else begin
      clock_count <= clock_count + 1'b1;  // free running, wraps
      data_out.valid <= '0;
      tstamps_out.valid <= '0;
      if (samples_in.valid) begin
        is_high <= next_high;
        data_out.valid <= next_high;
        tstamps_out.valid <= rising;
        for (int i = 0; i < ssb_pkg::channels; i++) begin
          if (next_high[i]) index[i] <= index[i] + 1'b1;
        end
      end
    end
  end

  // payload, qualified by the valids above
  always_ff @(posedge clk) begin
    data_out.data <= samples_in.data;
    for (int i = 0; i < ssb_pkg::channels; i++) begin
      tstamps_out.tstamp[i] <= {clock_count, index[i]};  // index before this sample
    end
  end

endmodule

//--- rtl/sample_buffer.sv
/* banked capture memory, one bank per channel
   captures between start and stop/full, then reads out count word + entries per bank */
`timescale 1ns/10ps
module sample_buffer #(
  parameter int WIDTH = 16,  // entry width
  parameter int DEPTH = 64   // entries per bank
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [ssb_pkg::channels-1:0]          wr_valid,
  input  logic [ssb_pkg::channels-1:0][WIDTH-1:0] wr_data,
  input  logic                                  start,
  input  logic                                  stop,
  input  logic                                  stop_other,  // the other buffer filled
  output logic                                  full,
  output logic [WIDTH-1:0]                      rd_data,
  output logic                                  rd_valid,
  output logic                                  rd_last,
  input  logic                                  rd_ready
);

  localparam int addr_width = $clog2(DEPTH);
  localparam int count_width = $clog2(DEPTH + 1);  // count reaches DEPTH

  typedef enum logic [1:0] {
    st_idle,
    st_capture,
    st_readout
  } state_e;

  state_e                                           state;
  logic [WIDTH-1:0]                                 mem [ssb_pkg::channels][DEPTH];
  logic [ssb_pkg::channels-1:0][count_width-1:0]    wr_ptr;  // doubles as bank count
  logic [ssb_pkg::channels-1:0]                     bank_full;
  logic [ssb_pkg::ch_sel_width-1:0]                 rd_ch;
  logic [count_width-1:0]                           rd_idx;  // 0 is the count word
  logic                                             rd_bank_end;
  logic                                             rd_last_ch;

  always_comb begin
    for (int i = 0; i < ssb_pkg::channels; i++) begin
      bank_full[i] = (wr_ptr[i] == count_width'(DEPTH));
    end
  end

  assign full = (state == st_capture) && (|bank_full);  // one cycle, state leaves capture

  // bank writes, dropped once the bank is full
  always_ff @(posedge clk) begin
    for (int i = 0; i < ssb_pkg::channels; i++) begin
      if (state == st_capture && wr_valid[i] && !bank_full[i]) begin
        mem[i][wr_ptr[i][addr_width-1:0]] <= wr_data[i];
      end
    end
  end

  assign rd_bank_end = (rd_idx == wr_ptr[rd_ch]);
  assign rd_last_ch = (rd_ch == ssb_pkg::ch_sel_width'(ssb_pkg::channels - 1));

  // readout word select
  always_comb begin
    if (rd_idx == '0) begin
      rd_data = WIDTH'(wr_ptr[rd_ch]);  // count word, zero extended
    end else begin
      rd_data = mem[rd_ch][addr_width'(rd_idx - count_width'(1))];
    end
  end

  assign rd_valid = (state == st_readout);
  assign rd_last = rd_valid && rd_last_ch && rd_bank_end;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      wr_ptr <= '0;
      rd_ch <= '0;
      rd_idx <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (start) begin
            state <= st_capture;
            wr_ptr <= '0;  // previous capture discarded
          end
        end
        st_capture: begin
          for (int i = 0; i < ssb_pkg::channels; i++) begin
            if (wr_valid[i] && !bank_full[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
          end
          if (stop || stop_other || full) begin
            state <= st_readout;
            rd_ch <= '0;
            rd_idx <= '0;
          end
        end
        st_readout: begin
          if (rd_ready) begin  // rd_valid is high throughout readout
            if (!rd_bank_end) begin
              rd_idx <= rd_idx + 1'b1;
            end else if (rd_last_ch) begin
              state <= st_idle;  // final word of last bank gone
            end else begin
              rd_ch <= rd_ch + 1'b1;
              rd_idx <= '0;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- rtl/sample_packer.sv
/* packs two 16-bit buffer words per 32-bit stream word, first word low
   an odd tail goes out with a zero upper half */
`timescale 1ns/10ps
module sample_packer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [ssb_pkg::sample_width-1:0]  in_data,
  input  logic                              in_valid,
  input  logic                              in_last,
  output logic                              in_ready,
  output ssb_pkg::out_stream_t              data_out,
  input  logic                              out_ready
);

  logic [ssb_pkg::sample_width-1:0] low_half;  // first word of a pair
  logic                             have_low;
  logic                             in_ok;  // input transfer
  logic                             emit;   // staged word loads this cycle

  // staged word can move when empty or leaving now
  assign in_ready = !data_out.valid || out_ready;
  assign in_ok = in_valid && in_ready;
  assign emit = in_ok && (have_low || in_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out.valid <= 1'b0;
      data_out.last <= 1'b0;
      have_low <= 1'b0;
    end else begin
      if (emit) begin
        data_out.valid <= 1'b1;
        data_out.last <= in_last;
        have_low <= 1'b0;
      end else begin
        if (out_ready) begin
          data_out.valid <= 1'b0;  // staged word taken, nothing new
          data_out.last <= 1'b0;
        end
        if (in_ok) have_low <= 1'b1;  // first half waits
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_ok && !have_low) low_half <= in_data;
    if (emit) begin
      if (have_low) begin
        data_out.data <= {in_data, low_half};
      end else begin
        data_out.data <= {{ssb_pkg::sample_width{1'b0}}, in_data};  // lone last word
      end
    end
  end

endmodule

//--- rtl/sparse_sample_buffer.sv
/* two-channel sparse capture: discriminator feeding a data and a timestamp buffer
   after a stop, all timestamps then the packed data leave on one stream */
`timescale 1ns/10ps
module sparse_sample_buffer (
  input  logic                    clk,
  input  logic                    reset,
  input  ssb_pkg::samples_t       samples_in,
  input  ssb_pkg::thresholds_t    thresholds_in,
  input  ssb_pkg::ssb_cmd_e       cmd_in,
  input  logic                    cmd_valid,
  input  logic                    start_aux,
  output ssb_pkg::out_stream_t    data_out,
  input  logic                    out_ready
);

  typedef enum logic {
    phase_tstamp,
    phase_data
  } phase_e;

  phase_e                               phase;
  logic                                 start_aux_q;
  logic                                 start_req, stop_req;
  logic                                 start_pulse, stop_pulse;
  logic                                 busy;  // capture or readout in flight
  logic                                 data_full, ts_full;
  ssb_pkg::disc_data_t                  disc_data;
  ssb_pkg::disc_tstamp_t                disc_tstamp;
  logic [ssb_pkg::sample_width-1:0]     buf_data;
  logic                                 buf_valid, buf_last, buf_ready;
  logic [ssb_pkg::tstamp_width-1:0]     ts_data;
  logic                                 ts_valid, ts_last, ts_ready;
  ssb_pkg::out_stream_t                 pk_out;
  logic                                 pk_ready;

  assign start_req = (cmd_valid && cmd_in == ssb_pkg::cmd_start) || (start_aux && !start_aux_q);
  assign stop_req = cmd_valid && (cmd_in == ssb_pkg::cmd_stop || cmd_in == ssb_pkg::cmd_start_stop);

  // one-cycle start/stop pulses, starts ignored until the last word has left
  always_ff @(posedge clk) begin
    if (reset) begin
      start_aux_q <= 1'b0;
      start_pulse <= 1'b0;
      stop_pulse <= 1'b0;
      busy <= 1'b0;
    end else begin
      start_aux_q <= start_aux;
      start_pulse <= start_req && !busy && !start_pulse;
      stop_pulse <= stop_req;
      if (start_pulse) begin
        busy <= 1'b1;
      end else if (data_out.valid && out_ready && data_out.last) begin
        busy <= 1'b0;  // both buffers back in idle
      end
    end
  end

  sample_discriminator disc_inst (
    .clk, .reset,
    .samples_in, .thresholds_in,
    .start(start_pulse),
    .data_out(disc_data),
    .tstamps_out(disc_tstamp)
  );

  sample_buffer #(.WIDTH(ssb_pkg::sample_width), .DEPTH(ssb_pkg::data_depth)) data_buf_inst (
    .clk, .reset,
    .wr_valid(disc_data.valid), .wr_data(disc_data.data),
    .start(start_pulse), .stop(stop_pulse),
    .stop_other(ts_full), .full(data_full),  // full flags cross-stop the buffers
    .rd_data(buf_data), .rd_valid(buf_valid), .rd_last(buf_last), .rd_ready(buf_ready)
  );

  sample_buffer #(.WIDTH(ssb_pkg::tstamp_width), .DEPTH(ssb_pkg::tstamp_depth)) ts_buf_inst (
    .clk, .reset,
    .wr_valid(disc_tstamp.valid), .wr_data(disc_tstamp.tstamp),
    .start(start_pulse), .stop(stop_pulse),
    .stop_other(data_full), .full(ts_full),
    .rd_data(ts_data), .rd_valid(ts_valid), .rd_last(ts_last), .rd_ready(ts_ready)
  );

  sample_packer packer_inst (
    .clk, .reset,
    .in_data(buf_data), .in_valid(buf_valid), .in_last(buf_last), .in_ready(buf_ready),
    .data_out(pk_out), .out_ready(pk_ready)
  );

  // timestamps first, then data
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phase_tstamp;
    end else begin
      unique case (phase)
        phase_tstamp: if (ts_valid && ts_ready && ts_last) phase <= phase_data;
        phase_data:   if (pk_out.valid && pk_ready && pk_out.last) phase <= phase_tstamp;
        default:      phase <= phase_tstamp;
      endcase
    end
  end

  always_comb begin
    if (phase == phase_tstamp) begin
      data_out.data = ts_data;  // same width as the stream
      data_out.valid = ts_valid;
      data_out.last = 1'b0;  // last only closes the data phase
    end else begin
      data_out = pk_out;
    end
  end

  assign ts_ready = out_ready && (phase == phase_tstamp);
  assign pk_ready = out_ready && (phase == phase_data);

endmodule

//--- bench/sparse_sample_buffer_assert.sv
/* output stream rules of the sparse sample buffer
   bound to the top level, watches the stream and both buffer states */
`timescale 1ns/10ps
module sparse_sample_buffer_assert (
  input logic                 clk,
  input logic                 reset,
  input ssb_pkg::out_stream_t data_out,
  input logic                 out_ready,
  input logic [1:0]           data_state,  // data buffer FSM state
  input logic [1:0]           ts_state     // timestamp buffer FSM state
);

  localparam logic [1:0] idle_state = 2'd0;
  localparam logic [1:0] capture_state = 2'd1;

  // a word waiting for ready keeps its payload
  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    data_out.valid && !out_ready |=> data_out.valid && $stable(data_out.data)
      && $stable(data_out.last))
    else $error("data_out changed while stalled");

  // readout never overlaps capture
  quiet_in_capture: assert property (@(posedge clk) disable iff (reset)
    data_out.valid && data_state == capture_state |-> 1'b0)
    else $error("data_out valid during capture");

  // last rides on a valid word, only once every timestamp has left
  last_after_tstamps: assert property (@(posedge clk) disable iff (reset)
    data_out.last |-> data_out.valid && ts_state == idle_state)
    else $error("last before the timestamp readout ended");

  idle_after_reset: assert property (@(posedge clk)
    reset |=> !data_out.valid && !data_out.last)
    else $error("data_out active after reset");

endmodule

bind sparse_sample_buffer sparse_sample_buffer_assert assert_inst (
  .clk(clk),
  .reset(reset),
  .data_out(data_out),
  .out_ready(out_ready),
  .data_state(data_buf_inst.state),
  .ts_state(ts_buf_inst.state)
);

//--- bench/sparse_sample_buffer_tb.sv
/* testbench for the sparse sample buffer
   drives captures, models the expected stream and compares every output word */
`timescale 1ns/10ps
module sparse_sample_buffer_tb;

  localparam int clk_period = 40;
  localparam int total_len = 100 + 100 + 300 + 400 + 600;  // cycles per test, summed

  logic                  clk;
  logic                  reset;
  ssb_pkg::samples_t     samples_in;
  ssb_pkg::thresholds_t  thresholds_in;
  ssb_pkg::ssb_cmd_e     cmd_in;
  logic                  cmd_valid;
  logic                  start_aux;
  ssb_pkg::out_stream_t  data_out;
  logic                  out_ready;

  int  cyc;  // drive cycles, only used relative to start_cyc
  int  start_cyc;
  bit  rec;  // record driven samples for the model
  bit  hold;  // keep out_ready low until the model is built
  bit  bp_en;
  int  errors;
  int  checks;
  int  got;
  ssb_pkg::samples_t                   cap_q[$];
  logic [ssb_pkg::clock_width-1:0]     cap_clk[$];
  ssb_pkg::out_stream_t                exp_q[$];
  logic [1:0][ssb_pkg::sample_width-1:0] cur_hi;
  logic [1:0][ssb_pkg::sample_width-1:0] cur_lo;

  sparse_sample_buffer sparse_sample_buffer_inst (
    .clk, .reset,
    .samples_in, .thresholds_in,
    .cmd_in, .cmd_valid, .start_aux,
    .data_out, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // expected stream from the driven samples and the held thresholds
  function automatic void ssb_model();
    logic [1:0]               hs;
    logic [7:0]               idx [2];
    logic [15:0]              dq [2][$];
    logic [31:0]              tq [2][$];
    logic [15:0]              w16 [$];
    logic                     nh;
    int                       stop_at;
    ssb_pkg::out_stream_t     w;
    hs = '0;
    idx[0] = '0;
    idx[1] = '0;
    stop_at = -1;
    for (int k = 0; k < cap_q.size(); k++) begin
      if (stop_at >= 0 && k > stop_at) break;  // one more cycle is written after full
      if (cap_q[k].valid) begin
        for (int ch = 0; ch < 2; ch++) begin
          if ($signed(cap_q[k].data[ch]) > $signed(cur_hi[ch])) nh = 1'b1;
          else if ($signed(cap_q[k].data[ch]) < $signed(cur_lo[ch])) nh = 1'b0;
          else nh = hs[ch];
          if (nh) begin
            if (!hs[ch] && tq[ch].size() < ssb_pkg::tstamp_depth)
              tq[ch].push_back({cap_clk[k], idx[ch]});
            if (dq[ch].size() < ssb_pkg::data_depth) dq[ch].push_back(cap_q[k].data[ch]);
            idx[ch] = idx[ch] + 8'd1;
          end
          hs[ch] = nh;
        end
      end
      for (int ch = 0; ch < 2; ch++) begin
        if (stop_at < 0 && (dq[ch].size() == ssb_pkg::data_depth
            || tq[ch].size() == ssb_pkg::tstamp_depth)) stop_at = k + 1;
      end
    end
    w.valid = 1'b1;
    w.last = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
      w.data = 32'(tq[ch].size());  // count word first
      exp_q.push_back(w);
      for (int i = 0; i < tq[ch].size(); i++) begin
        w.data = tq[ch][i];
        exp_q.push_back(w);
      end
      w16.push_back(16'(dq[ch].size()));
      for (int i = 0; i < dq[ch].size(); i++) w16.push_back(dq[ch][i]);
    end
    for (int i = 0; i < w16.size(); i += 2) begin
      w.data[15:0] = w16[i];
      w.data[31:16] = (i + 1 < w16.size()) ? w16[i + 1] : 16'h0;  // odd tail padded
      w.last = (i + 2 >= w16.size());
      exp_q.push_back(w);
    end
  endfunction

  task automatic check_word(input string name, input ssb_pkg::out_stream_t exp_w,
                            input ssb_pkg::out_stream_t act_w);
    checks++;
    if (exp_w !== act_w) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp_w, act_w);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] exp_n,
                             input logic [31:0] act_n);
    checks++;
    if (exp_n !== act_n) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp_n, act_n);
    end
  endtask

  // compare every transferred word against the model
  always @(posedge clk) begin
    if (!reset && data_out.valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output word %h arrived with no word expected", data_out.data);
      end else begin
        check_word("data_out", exp_q.pop_front(), data_out);
      end
      got++;
    end
  end

  always @(posedge clk) begin
    if (hold) out_ready <= 1'b0;
    else if (bp_en) out_ready <= 1'($urandom % 2);  // random stalls
    else out_ready <= 1'b1;
  end

  initial begin
    #(64'(total_len) * 4 * clk_period);
    $display("timeout: readout did not finish within the time limit");
    $display("tests failed");
    $finish;
  end

  function automatic ssb_pkg::samples_t rand_samples();
    ssb_pkg::samples_t s;
    s.valid = 1'b1;
    s.data[0] = 16'($urandom);
    s.data[1] = 16'($urandom);
    return s;
  endfunction

  task automatic step_samples(input ssb_pkg::samples_t s);
    @(posedge clk);
    cyc++;
    samples_in <= s;
    if (rec) begin
      cap_q.push_back(s);
      cap_clk.push_back(24'(cyc - start_cyc - 2));  // start pulse lands two cycles later
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step_samples('0);
  endtask

  task automatic write_thresholds(input logic [1:0][15:0] hi, input logic [1:0][15:0] lo);
    ssb_pkg::thresholds_t t;
    t.valid = 1'b1;
    t.high = hi;
    t.low = lo;
    @(posedge clk);
    cyc++;
    thresholds_in <= t;
    cur_hi = hi;
    cur_lo = lo;
    @(posedge clk);
    cyc++;
    thresholds_in.valid <= 1'b0;
  endtask

  task automatic random_thresholds();
    logic [1:0][15:0] hi;
    logic [1:0][15:0] lo;
    for (int ch = 0; ch < 2; ch++) begin
      hi[ch] = 16'($urandom % 16384);
      lo[ch] = 16'(32'd0 - ($urandom % 16384));  // negative low threshold
    end
    write_thresholds(hi, lo);
  endtask

  task automatic start_capture(input bit aux);
    @(posedge clk);
    cyc++;
    start_cyc = cyc;
    samples_in <= '0;
    if (aux) begin
      start_aux <= 1'b1;
    end else begin
      cmd_in <= ssb_pkg::cmd_start;
      cmd_valid <= 1'b1;
    end
    @(posedge clk);
    cyc++;
    start_aux <= 1'b0;
    cmd_valid <= 1'b0;
    cmd_in <= ssb_pkg::cmd_none;
    cap_q.delete();
    cap_clk.delete();
    rec = 1'b1;
  endtask

  task automatic stop_capture();
    rec = 1'b0;
    @(posedge clk);
    cyc++;
    cmd_in <= ssb_pkg::cmd_stop;
    cmd_valid <= 1'b1;
    @(posedge clk);
    cyc++;
    cmd_valid <= 1'b0;
    cmd_in <= ssb_pkg::cmd_none;
  endtask

  // mode 0 few samples, 1 hand waveform, 2 fill channel 0, 3 random burst
  task automatic run_test(input int num, input string name, input bit aux, input bit bp,
                          input int mode);
    int                 e0;
    int                 n_exp;
    ssb_pkg::samples_t  s;
    logic [15:0]        wave [10] = '{16'h0000, 16'h0032, 16'h0096, 16'h0032, 16'hffce,
                                      16'hff6a, 16'h0000, 16'h00c8, 16'h0078, 16'hff38};
    e0 = errors;
    got = 0;
    hold = 1'b1;
    bp_en = bp;
    start_capture(aux);
    idle_cycles(3);
    case (mode)
      0: repeat (6) step_samples(rand_samples());
      1: begin
        foreach (wave[i]) begin
          s.valid = 1'b1;
          s.data[0] = wave[i];
          s.data[1] = 16'h0;
          step_samples(s);
        end
      end
      2: begin
        repeat (80) begin
          s = rand_samples();
          s.data[0] = 16'd5000;  // held high
          step_samples(s);
        end
      end
      default: repeat (40) step_samples(rand_samples());
    endcase
    idle_cycles(3);
    if (mode != 2) stop_capture();
    else rec = 1'b0;  // stopped itself on full
    ssb_model();
    n_exp = exp_q.size();
    hold = 1'b0;
    while (exp_q.size() > 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check_count("word_count", 32'(n_exp), 32'(got));
    $display("test %0d %s: %s", num, name, (errors == e0) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(42124));
    reset <= 1'b1;
    samples_in <= '0;
    thresholds_in <= '0;
    cmd_in <= ssb_pkg::cmd_none;
    cmd_valid <= 1'b0;
    start_aux <= 1'b0;
    out_ready <= 1'b0;
    cur_hi = {2{ssb_pkg::thresh_high_init}};
    cur_lo = {2{ssb_pkg::thresh_low_init}};
    hold = 1'b1;
    bp_en = 1'b0;
    rec = 1'b0;
    errors = 0;
    checks = 0;
    got = 0;
    cyc = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    run_test(1, "reset thresholds", 1'b0, 1'b0, 0);
    write_thresholds({16'h0064, 16'h0064}, {16'hff9c, 16'hff9c});  // +-100
    run_test(2, "hysteresis waveform", 1'b0, 1'b0, 1);
    random_thresholds();
    run_test(3, "random capture", 1'b0, 1'b0, 3);
    write_thresholds({16'h6000, 16'h03e8}, {16'ha000, 16'hfc18});  // ch0 +-1000
    run_test(4, "aux start fill", 1'b1, 1'b0, 2);
    random_thresholds();
    run_test(5, "random backpressure", 1'b0, 1'b1, 3);
    $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
rtl/ssb_pkg.sv
rtl/sample_discriminator.sv
rtl/sample_buffer.sv
rtl/sample_packer.sv
rtl/sparse_sample_buffer.sv
bench/sparse_sample_buffer_assert.sv
bench/sparse_sample_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sparse sample buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module sparse_sample_buffer_tb \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi
